/* softmax_norm.f */
hdl/norm_pkg.sv
hdl/divider.sv
hdl/norm_dispatch.sv
hdl/norm_collect.sv
hdl/softmax_norm.sv
tests/softmax_norm_asserts.sv
tests/softmax_norm_tb.sv

/* Makefile */
# Verilator build and run of the softmax normalization testbench

TOP = softmax_norm_tb

.PHONY: all compile run clean

all: run

compile: obj_dir/$(TOP)

obj_dir/$(TOP): softmax_norm.f hdl/*.sv tests/*.sv
	verilator --binary --timing --assert -j 0 \
		-f softmax_norm.f \
		--top-module $(TOP) \
		-Mdir obj_dir -o $(TOP)

# the log decides, the simulator status alone is not enough
run: compile
	./obj_dir/$(TOP) | tee sim.log
	@grep -q "^PASS: all tests$$" sim.log || \
		(echo "simulation failed, see sim.log"; exit 1)

clean:
	rm -rf obj_dir sim.log

/* tests/softmax_norm_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module softmax_norm_tb;

    localparam int FRAC_W  = 13;
    localparam int TIMEOUT = 4000;  // 40 vectors at about 70 cycles
    localparam int N_RAND  = 28;
    localparam int EW      = norm_pkg::ELEM_W;
    localparam logic [norm_pkg::IDX_W-1:0] LAST_IDX = norm_pkg::IDX_W'(norm_pkg::N_ELEM - 1);

    logic                I_CLK;
    logic                I_RST_N;
    logic                in_vld;
    norm_pkg::norm_vec_t in_vec;
    logic                busy;
    logic                out_vld;
    norm_pkg::norm_out_t out_elem;
    logic                done;

    logic [31:0]         lfsr;
    norm_pkg::norm_out_t exp_q[$];  // expected elements in output order
    int                  errors;
    int                  n_out;
    int                  n_done;
    int                  exp_done;
    int                  cycles;

    softmax_norm #(
        .FRAC_W (FRAC_W)
    ) UUT (
        .I_CLK    (I_CLK),
        .I_RST_N  (I_RST_N),
        .in_vld   (in_vld),
        .in_vec   (in_vec),
        .busy     (busy),
        .out_vld  (out_vld),
        .out_elem (out_elem),
        .done     (done)
    );

    always #5 I_CLK = ~I_CLK;

    ////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////
    // taps 32 31 29 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        lfsr_step = s[0] ? ((s >> 1) ^ 32'hd000_0001) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val  = {val[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    function automatic logic [31:0] vec_sum(input norm_pkg::norm_vec_t v);
        logic [31:0] s;
        s = '0;
        for (int i = 0; i < norm_pkg::N_ELEM; i++) begin
            s = s + 32'(v[i]);
        end
        vec_sum = s;
    endfunction

    // floor(x * 2^FRAC_W / sum)
    function automatic logic [norm_pkg::QUO_W-1:0] ref_prob(input logic [EW-1:0] x,
                                                            input logic [31:0] sum);
        logic [31:0] num;
        num      = 32'(x) << FRAC_W;
        ref_prob = norm_pkg::QUO_W'(num / sum);
    endfunction

    task automatic random_vector(output norm_pkg::norm_vec_t v);
        logic [31:0] r;
        logic [31:0] sel;
        for (int i = 0; i < norm_pkg::N_ELEM; i++) begin
            take_bits(2, sel);
            take_bits(EW, r);
            v[i] = (sel == 0) ? {{(EW-4){1'b0}}, r[3:0]} : r[EW-1:0];  // some small ones
        end
    endtask

    task automatic drive_vector(input norm_pkg::norm_vec_t v);
        in_vec = v;
        in_vld = 1'b1;
        @(negedge I_CLK);
        in_vld = 1'b0;
    endtask

    task automatic send_vector(input norm_pkg::norm_vec_t v);
        logic [31:0]         s;
        norm_pkg::norm_out_t e;
        s = vec_sum(v);
        while (busy) begin
            @(negedge I_CLK);
        end
        if (s != 0) begin
            for (int i = 0; i < norm_pkg::N_ELEM; i++) begin
                e.idx  = norm_pkg::IDX_W'(i);
                e.prob = ref_prob(v[i], s);
                exp_q.push_back(e);
            end
            exp_done++;
        end
        drive_vector(v);
    endtask

    task automatic wait_idle();
        while (exp_q.size() != 0 || busy) begin
            @(negedge I_CLK);
        end
    endtask

    ////////////////////////////////////////
    // comparing process
    ////////////////////////////////////////
    always @(negedge I_CLK) begin
        norm_pkg::norm_out_t e;
        if (I_RST_N) begin
            if (UUT.res_even.vld != UUT.res_odd.vld) begin
                $display("%0t: divider lanes finished on different cycles", $time);
                errors++;
            end
            if (done && !out_vld) begin
                $display("%0t: done is high without out_vld", $time);
                errors++;
            end
            if (out_vld && !busy) begin
                $display("%0t: out_vld is high while busy is low", $time);
                errors++;
            end
            if (out_vld) begin
                n_out++;
                if (done) begin
                    n_done++;
                end
                if (exp_q.size() == 0) begin
                    $display("%0t: unexpected output, idx %0d prob %0d", $time,
                             out_elem.idx, out_elem.prob);
                    errors++;
                end else begin
                    e = exp_q.pop_front();
                    if (out_elem.idx !== e.idx) begin
                        $display("CHECK FAILED at %0t: out_elem.idx got %0d expected %0d",
                                 $time, out_elem.idx, e.idx);
                        errors++;
                    end
                    if (out_elem.prob !== e.prob) begin
                        $display("CHECK FAILED at %0t: out_elem.prob got %0d expected %0d",
                                 $time, out_elem.prob, e.prob);
                        errors++;
                    end
                    if (done !== (e.idx == LAST_IDX)) begin
                        $display("CHECK FAILED at %0t: done got %0b expected %0b",
                                 $time, done, e.idx == LAST_IDX);
                        errors++;
                    end
                end
            end
        end
    end

    always @(posedge I_CLK) begin
        cycles++;
        if (cycles >= TIMEOUT) begin
            $display("timeout after %0d cycles, the stage never finished", cycles);
            $display("outputs %0d, vectors done %0d, errors %0d", n_out, n_done, errors);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////
    initial begin
        norm_pkg::norm_vec_t v;
        logic [31:0]         r;
        int                  n_before;
        I_CLK    = 1'b0;
        I_RST_N  = 1'b0;
        in_vld   = 1'b0;
        in_vec   = '0;
        lfsr     = 32'hb1ae;
        errors   = 0;
        n_out    = 0;
        n_done   = 0;
        exp_done = 0;
        cycles   = 0;
        repeat (2) @(posedge I_CLK);
        @(negedge I_CLK);
        I_RST_N = 1'b1;

        for (int n = 0; n < N_RAND; n++) begin
            random_vector(v);
            send_vector(v);
        end

        for (int i = 0; i < norm_pkg::N_ELEM; i++) begin  // one element carries the sum
            take_bits(EW, r);
            v    = '0;
            v[i] = r[EW-1:0] | 12'h001;
            send_vector(v);
        end
        send_vector({norm_pkg::N_ELEM{12'hfff}});
        wait_idle();

        n_before = n_out;
        send_vector('0);  // zero sum
        wait_idle();
        if (n_out != n_before) begin
            $display("zero-sum vector produced %0d outputs", n_out - n_before);
            errors++;
        end

        random_vector(v);
        send_vector(v);
        repeat (5) @(negedge I_CLK);
        if (!busy) begin
            $display("CHECK FAILED at %0t: busy got 0 expected 1", $time);
            errors++;
        end
        random_vector(v);
        drive_vector(v);  // must be ignored
        wait_idle();
        if (n_out != n_before + norm_pkg::N_ELEM) begin
            $display("vector sent while busy changed the output count to %0d",
                     n_out - n_before);
            errors++;
        end

        random_vector(v);
        send_vector(v);
        repeat (12) @(negedge I_CLK);
        I_RST_N = 1'b0;  // mid-division
        exp_q.delete();
        exp_done--;
        repeat (2) @(negedge I_CLK);
        I_RST_N = 1'b1;
        @(negedge I_CLK);
        if (busy || out_vld) begin
            $display("CHECK FAILED at %0t: busy/out_vld got %0b%0b expected 00",
                     $time, busy, out_vld);
            errors++;
        end
        random_vector(v);
        send_vector(v);
        wait_idle();

        if (n_done != exp_done || n_out != exp_done * norm_pkg::N_ELEM) begin
            $display("saw %0d outputs and %0d done, expected %0d vectors",
                     n_out, n_done, exp_done);
            errors++;
        end
        $display("outputs %0d, vectors done %0d, errors %0d", n_out, n_done, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tests/softmax_norm_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module softmax_norm_asserts (
    input logic I_CLK,
    input logic I_RST_N,
    input logic vld_even,
    input logic vld_odd,
    input logic out_vld,
    input logic done,
    input logic busy
);

    // both lanes always run divisions of equal length
    lanes_in_step: assert property (@(posedge I_CLK) disable iff (!I_RST_N)
        vld_even == vld_odd)
        else $error("divider lane vld pulses differ");

    // last element right behind its even partner
    done_with_vld: assert property (@(posedge I_CLK) disable iff (!I_RST_N)
        done |-> out_vld && $past(out_vld))
        else $error("done without out_vld on it and on the cycle before");

    vld_while_busy: assert property (@(posedge I_CLK) disable iff (!I_RST_N)
        out_vld |-> busy)
        else $error("out_vld while not busy");

endmodule

bind softmax_norm softmax_norm_asserts u_asserts (
    .I_CLK    (I_CLK),
    .I_RST_N  (I_RST_N),
    .vld_even (res_even.vld),
    .vld_odd  (res_odd.vld),
    .out_vld  (out_vld),
    .done     (done),
    .busy     (busy)
);

`default_nettype wire

/* hdl/softmax_norm.sv */
`timescale 1ns/1ps
`default_nettype none

module softmax_norm #(
    parameter int FRAC_W = 13
) (
    input  logic                I_CLK,
    input  logic                I_RST_N,
    input  logic                in_vld,
    input  norm_pkg::norm_vec_t in_vec,
    output logic                busy,
    output logic                out_vld,
    output norm_pkg::norm_out_t out_elem,
    output logic                done
);

    norm_pkg::lane_req_t req_even;
    norm_pkg::lane_req_t req_odd;
    norm_pkg::lane_res_t res_even;
    norm_pkg::lane_res_t res_odd;

    norm_dispatch u_dispatch (
        .I_CLK    (I_CLK),
        .I_RST_N  (I_RST_N),
        .in_vld   (in_vld),
        .in_vec   (in_vec),
        .res_even (res_even),
        .res_odd  (res_odd),
        .req_even (req_even),
        .req_odd  (req_odd),
        .busy     (busy)
    );

    ////////////////////////////////////////
    // two divider lanes, even and odd elements
    ////////////////////////////////////////
    divider #(
        .D_W    (norm_pkg::QUO_W),
        .FRAC_W (FRAC_W)
    ) lane_even (
        .I_CLK     (I_CLK),
        .I_RST_N   (I_RST_N),
        .div_start (req_even.start),
        .dividend  (req_even.dividend),
        .divisor   (req_even.divisor),
        .quotient  (res_even.quotient),
        .vld       (res_even.vld)
    );

    divider #(
        .D_W    (norm_pkg::QUO_W),
        .FRAC_W (FRAC_W)
    ) lane_odd (
        .I_CLK     (I_CLK),
        .I_RST_N   (I_RST_N),
        .div_start (req_odd.start),
        .dividend  (req_odd.dividend),
        .divisor   (req_odd.divisor),
        .quotient  (res_odd.quotient),
        .vld       (res_odd.vld)
    );

    norm_collect u_collect (
        .I_CLK    (I_CLK),
        .I_RST_N  (I_RST_N),
        .res_even (res_even),
        .res_odd  (res_odd),
        .out_vld  (out_vld),
        .out_elem (out_elem),
        .done     (done)
    );

endmodule

`default_nettype wire

/* hdl/norm_collect.sv */
`timescale 1ns/1ps
`default_nettype none

module norm_collect (
    input  logic                I_CLK,
    input  logic                I_RST_N,
    input  norm_pkg::lane_res_t res_even,
    input  norm_pkg::lane_res_t res_odd,
    output logic                out_vld,
    output norm_pkg::norm_out_t out_elem,
    output logic                done
);

    localparam int PAIR_W = norm_pkg::IDX_W - 1;
    localparam logic [norm_pkg::IDX_W-1:0] LAST_IDX = norm_pkg::IDX_W'(norm_pkg::N_ELEM - 1);

    logic [PAIR_W-1:0]          pair_q;
    logic [norm_pkg::IDX_W-1:0] idx_even;
    logic [norm_pkg::IDX_W-1:0] idx_odd;
    logic                       last_odd;
    logic                       hold_vld;
    logic [norm_pkg::QUO_W-1:0] hold_q;

    // index is 2*pair + lane
    assign idx_even = {pair_q, 1'b0};
    assign idx_odd  = {pair_q, 1'b1};
    assign last_odd = (idx_odd == LAST_IDX);

    ////////////////////////////////////////
    // strobes and pair count
    ////////////////////////////////////////
    always_ff @(posedge I_CLK or negedge I_RST_N) begin
        if (!I_RST_N) begin
            out_vld  <= 1'b0;
            done     <= 1'b0;
            hold_vld <= 1'b0;
            pair_q   <= '0;
        end else begin
            hold_vld <= res_odd.vld;
            out_vld  <= res_even.vld | hold_vld;
            done     <= hold_vld & last_odd;
            if (hold_vld) begin
                pair_q <= last_odd ? '0 : pair_q + 1'b1;  // wrap for next vector
            end
        end
    end

    ////////////////////////////////////////
    // payload
    ////////////////////////////////////////
    always_ff @(posedge I_CLK) begin
        if (res_odd.vld) begin
            hold_q <= res_odd.quotient;  // waits one cycle behind even
        end
        if (hold_vld) begin
            out_elem.idx  <= idx_odd;
            out_elem.prob <= hold_q;
        end else if (res_even.vld) begin
            out_elem.idx  <= idx_even;
            out_elem.prob <= res_even.quotient;
        end
    end

endmodule

`default_nettype wire

/* hdl/norm_dispatch.sv */
`timescale 1ns/1ps
`default_nettype none

module norm_dispatch (
    input  logic                I_CLK,
    input  logic                I_RST_N,
    input  logic                in_vld,
    input  norm_pkg::norm_vec_t in_vec,
    input  norm_pkg::lane_res_t res_even,
    input  norm_pkg::lane_res_t res_odd,
    output norm_pkg::lane_req_t req_even,
    output norm_pkg::lane_req_t req_odd,
    output logic                busy
);

    localparam int QW     = norm_pkg::QUO_W;
    localparam int EW     = norm_pkg::ELEM_W;
    localparam int SUM_W  = norm_pkg::ELEM_W + norm_pkg::IDX_W;
    localparam int PAIR_W = norm_pkg::IDX_W - 1;
    localparam logic [PAIR_W-1:0] LAST_PAIR = PAIR_W'(norm_pkg::N_ELEM / 2 - 1);

    typedef enum logic [2:0] {
        s_idle,
        s_check,   // vector and sum registered
        s_run,     // both lanes dividing
        s_gap,
        s_tail     // last odd result still in the collector
    } state_t;

    state_t state;

    norm_pkg::norm_vec_t        vec_q;
    logic [SUM_W-1:0]           sum_q;
    logic [SUM_W-1:0]           in_sum;
    logic [PAIR_W-1:0]          pair_q;
    logic                       start_even;
    logic                       start_odd;
    logic                       got_even;
    logic                       got_odd;
    logic                       pair_done;
    logic [norm_pkg::IDX_W-1:0] idx_even;
    logic [norm_pkg::IDX_W-1:0] idx_odd;

    always_comb begin
        in_sum = '0;
        for (int i = 0; i < norm_pkg::N_ELEM; i++) begin
            in_sum = in_sum + SUM_W'(in_vec[i]);
        end
    end

    assign pair_done = (got_even | res_even.vld) & (got_odd | res_odd.vld);
    assign idx_even  = {pair_q, 1'b0};
    assign idx_odd   = {pair_q, 1'b1};

    // operands stay put for the whole pair
    assign req_even.start    = start_even;
    assign req_even.dividend = {{(QW-EW){1'b0}}, vec_q[idx_even]};
    assign req_even.divisor  = {{(QW-SUM_W){1'b0}}, sum_q};
    assign req_odd.start     = start_odd;
    assign req_odd.dividend  = {{(QW-EW){1'b0}}, vec_q[idx_odd]};
    assign req_odd.divisor   = {{(QW-SUM_W){1'b0}}, sum_q};

    always_ff @(posedge I_CLK) begin
        if (state == s_idle && in_vld) begin
            vec_q <= in_vec;
            sum_q <= in_sum;
        end
    end

    always_ff @(posedge I_CLK or negedge I_RST_N) begin
        if (!I_RST_N) begin
            state      <= s_idle;
            busy       <= 1'b0;
            pair_q     <= '0;
            start_even <= 1'b0;
            start_odd  <= 1'b0;
            got_even   <= 1'b0;
            got_odd    <= 1'b0;
        end else begin
            case (state)
                s_idle: begin
                    if (in_vld) begin
                        busy  <= 1'b1;
                        state <= s_check;
                    end
                end
                s_check: begin
                    if (sum_q == '0) begin
                        busy  <= 1'b0;  // nothing to normalize
                        state <= s_idle;
                    end else begin
                        start_even <= 1'b1;
                        start_odd  <= 1'b1;
                        state      <= s_run;
                    end
                end
                s_run: begin
                    if (res_even.vld) begin
                        start_even <= 1'b0;
                        got_even   <= 1'b1;
                    end
                    if (res_odd.vld) begin
                        start_odd <= 1'b0;
                        got_odd   <= 1'b1;
                    end
                    if (pair_done) begin
                        got_even <= 1'b0;
                        got_odd  <= 1'b0;
                        state    <= s_gap;
                    end
                end
                s_gap: begin
                    if (pair_q == LAST_PAIR) begin
                        pair_q <= '0;
                        state  <= s_tail;
                    end else begin
                        pair_q     <= pair_q + 1'b1;
                        start_even <= 1'b1;
                        start_odd  <= 1'b1;
                        state      <= s_run;
                    end
                end
                s_tail: begin
                    busy  <= 1'b0;  // done is on the output now
                    state <= s_idle;
                end
                default: begin
                    state <= s_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/divider.sv */
`timescale 1ns/1ps
`default_nettype none

module divider #(
    parameter int D_W    = 16,
    parameter int FRAC_W = 13
) (
    input  logic           I_CLK,
    input  logic           I_RST_N,
    input  logic           div_start,  // hold high until vld
    input  logic [D_W-1:0] dividend,   // hold while div_start
    input  logic [D_W-1:0] divisor,    // hold while div_start
    output logic [D_W-1:0] quotient,
    output logic           vld
);

    localparam int A_W = D_W - 1 + FRAC_W;  // dividend magnitude after the shift
    localparam int K_W = $clog2(A_W);
    localparam logic [K_W-1:0] K_TOP = K_W'(A_W - 1);

    typedef enum logic [3:0] {
        s_idle  = 4'b0001,
        s_start = 4'b0010,
        s_calc  = 4'b0100,
        s_end   = 4'b1000
    } state_t;

    state_t state;

    logic           dvd_neg;
    logic           dvs_neg;
    logic           q_neg;
    logic [D_W-2:0] dvd_abs;
    logic [D_W-2:0] dvs_abs;
    logic [A_W-1:0] dvd_sh;
    logic [D_W-1:0] rem_q;
    logic [D_W-1:0] rem_sub;
    logic [D_W-1:0] rem_next;
    logic [A_W-1:0] quo_q;
    logic [A_W-1:0] quo_sgn;
    logic [K_W-1:0] k;      // current quotient bit
    logic           ge;
    logic           next_bit;

    ////////////////////////////////////////
    // operand magnitudes
    ////////////////////////////////////////
    assign dvd_neg = dividend[D_W-1];
    assign dvs_neg = divisor[D_W-1];
    assign dvd_abs = dvd_neg ? (~dividend[D_W-2:0] + 1'b1) : dividend[D_W-2:0];
    assign dvs_abs = dvs_neg ? (~divisor[D_W-2:0] + 1'b1) : divisor[D_W-2:0];
    assign dvd_sh  = {dvd_abs, {FRAC_W{1'b0}}};  // fraction bits below the integer part

    ////////////////////////////////////////
    // one trial subtraction per cycle
    ////////////////////////////////////////
    assign ge       = rem_q >= {1'b0, dvs_abs};
    assign rem_sub  = rem_q - {1'b0, dvs_abs};
    assign next_bit = (k != '0) ? dvd_sh[k - 1'b1] : 1'b0;
    assign rem_next = ge ? {rem_sub[D_W-2:0], next_bit} : {rem_q[D_W-2:0], next_bit};

    // sign back on, never a negative zero
    assign q_neg    = (quo_q != '0) & (dvd_neg ^ dvs_neg);
    assign quo_sgn  = q_neg ? (~quo_q + 1'b1) : quo_q;
    assign quotient = {q_neg, quo_sgn[D_W-2:0]};
    assign vld      = (state == s_end);

    always_ff @(posedge I_CLK or negedge I_RST_N) begin
        if (!I_RST_N) begin
            state <= s_idle;
            k     <= K_TOP;
        end else begin
            case (state)
                s_idle: begin
                    k <= K_TOP;
                    if (div_start) begin
                        state <= s_start;
                    end
                end
                s_start: begin
                    state <= div_start ? s_calc : s_idle;
                end
                s_calc: begin
                    if (!div_start) begin
                        state <= s_idle;  // request withdrawn, drop it
                    end else if (k == '0) begin
                        state <= s_end;
                    end else begin
                        k <= k - 1'b1;
                    end
                end
                s_end: begin
                    state <= s_idle;
                end
                default: begin
                    state <= s_idle;
                end
            endcase
        end
    end

    always_ff @(posedge I_CLK) begin
        if (state == s_start) begin
            rem_q <= {{(D_W-1){1'b0}}, dvd_sh[k]};  // top dividend bit first
            quo_q <= '0;
        end else if (state == s_calc) begin
            quo_q[k] <= ge;
            rem_q    <= rem_next;
        end
    end

endmodule

`default_nettype wire

/* hdl/norm_pkg.sv */
`default_nettype none

////////////////////////////////////////
// softmax normalization stage types
////////////////////////////////////////
package norm_pkg;

    localparam int N_ELEM = 4;   // elements per vector
    localparam int ELEM_W = 12;  // unsigned exponent value
    localparam int IDX_W  = 2;   // element index
    localparam int QUO_W  = 16;  // divider operands and result

    // element i sits at bits [i*ELEM_W +: ELEM_W]
    typedef logic [N_ELEM-1:0][ELEM_W-1:0] norm_vec_t;

    ////////////////////////////////////////
    // divider lane
    ////////////////////////////////////////
    typedef struct packed {
        logic             start;     // level, held until vld
        logic [QUO_W-1:0] dividend;
        logic [QUO_W-1:0] divisor;
    } lane_req_t;

    typedef struct packed {
        logic             vld;       // one-cycle pulse
        logic [QUO_W-1:0] quotient;
    } lane_res_t;

    ////////////////////////////////////////
    // output stream
    ////////////////////////////////////////
    typedef struct packed {
        logic [IDX_W-1:0] idx;
        logic [QUO_W-1:0] prob;      // 8192 means 1.0
    } norm_out_t;

endpackage

`default_nettype wire
